// ==== verilog/erithcrypt_config.svh ====
`ifndef ERITHCRYPT_CONFIG_SVH
`define ERITHCRYPT_CONFIG_SVH

// global sizing for the erithcrypt unit

// operand and result width
`define ERITH_DATA_W 8

// opcode field width
`define ERITH_OP_W 4

// queued commands between issue and execute
`define ERITH_FIFO_DEPTH 4

// fixed modulus of the congruence test
`define ERITH_CONG_MOD 5

// operand to result latency of single-cycle ops is one clock
// in the executor, gcd iterates until the smaller value reaches zero
// none of these are meant to change at run time

`endif

// ==== verilog/erithcrypt_pkg.sv ====
`include "erithcrypt_config.svh"

package erithcrypt_pkg;

    // one operand or result word
    typedef logic [`ERITH_DATA_W-1:0] data_t;

    // command opcodes
    // 0 and 8..15 are not legal and never reach the queue
    typedef enum logic [`ERITH_OP_W-1:0] {
        op_none      = 4'd0,
        op_gcd       = 4'd1,
        op_mod       = 4'd2,
        op_shl       = 4'd3,
        op_shr       = 4'd4,
        op_mat_add   = 4'd5,
        op_mat_mul   = 4'd6,
        op_congruent = 4'd7
    } opcode_t;

    // executor FSM
    // st_idle     waits for a command, issues pop
    // st_gcd_run  one euclid step per clock
    // st_done     result_valid cycle, back to idle next
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_gcd_run = 2'd1,
        st_done    = 2'd2
    } exec_state_t;

    // matrix operands are 2x2 of 2-bit elements
    // row-major, element [0][0] in the top bits

endpackage

// ==== verilog/op_issue.sv ====
`timescale 1ns/100ps

module op_issue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  erithcrypt_pkg::opcode_t op,
    input  erithcrypt_pkg::data_t  a,
    input  erithcrypt_pkg::data_t  b,
    output logic                   push,
    output erithcrypt_pkg::opcode_t push_op,
    output erithcrypt_pkg::data_t  push_a,
    output erithcrypt_pkg::data_t  push_b,
    output logic                   op_error
);

    logic legal;
    logic swap;

    // legal set is the contiguous range gcd..congruent
    assign legal = (op inside {[erithcrypt_pkg::op_gcd : erithcrypt_pkg::op_congruent]});

    // gcd and mod want the larger operand first
    // equal operands stay as they are
    assign swap = ((op == erithcrypt_pkg::op_gcd) || (op == erithcrypt_pkg::op_mod))
                  && (b > a);

    // control pulses, one cycle after start is sampled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            push     <= 1'b0;
            op_error <= 1'b0;
        end else begin
            // push and op_error are mutually exclusive
            push     <= start && legal;
            op_error <= start && !legal;
        end
    end

    // command payload
    // only loaded on a strobe, held otherwise
    always_ff @(posedge clk) begin
        if (start) begin
            push_op <= op;
            if (swap) begin
                push_a <= b;
                push_b <= a;
            end else begin
                // other ops keep caller order
                push_a <= a;
                push_b <= b;
            end
        end
    end

    // an illegal opcode still updates push_op
    // harmless since push stays low for it

endmodule

// ==== verilog/cmd_fifo.sv ====
`timescale 1ns/100ps

`include "erithcrypt_config.svh"

module cmd_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  erithcrypt_pkg::opcode_t push_op,
    input  erithcrypt_pkg::data_t   push_a,
    input  erithcrypt_pkg::data_t   push_b,
    input  logic                    pop,
    output erithcrypt_pkg::opcode_t head_op,
    output erithcrypt_pkg::data_t   head_a,
    output erithcrypt_pkg::data_t   head_b,
    output logic                    empty,
    output logic                    full
);

    localparam int DEPTH = `ERITH_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // one storage array per command field
    erithcrypt_pkg::opcode_t op_mem [DEPTH];
    erithcrypt_pkg::data_t   a_mem  [DEPTH];
    erithcrypt_pkg::data_t   b_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // a push while full only goes in if the head leaves the same cycle
    assign push_ok = push && (!full || pop);
    assign pop_ok  = pop && !empty;

    // head is read straight out of storage
    assign head_op = op_mem[rd_ptr];
    assign head_a  = a_mem[rd_ptr];
    assign head_b  = b_mem[rd_ptr];

    // pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave count alone
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (push_ok) begin
            op_mem[wr_ptr] <= push_op;
            a_mem[wr_ptr]  <= push_a;
            b_mem[wr_ptr]  <= push_b;
        end
    end

endmodule

// ==== verilog/op_execute.sv ====
`timescale 1ns/100ps

`include "erithcrypt_config.svh"

module op_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    empty,
    input  erithcrypt_pkg::opcode_t head_op,
    input  erithcrypt_pkg::data_t   head_a,
    input  erithcrypt_pkg::data_t   head_b,
    output logic                    pop,
    output erithcrypt_pkg::data_t   result,
    output logic                    result_valid
);

    localparam erithcrypt_pkg::data_t CONG_MOD = `ERITH_CONG_MOD;

    erithcrypt_pkg::exec_state_t state;
    erithcrypt_pkg::data_t       alu_result;
    erithcrypt_pkg::data_t       gcd_big;
    erithcrypt_pkg::data_t       gcd_small;

    // remainder with zero divisor mapped to 0
    function automatic erithcrypt_pkg::data_t remainder(
        input erithcrypt_pkg::data_t num,
        input erithcrypt_pkg::data_t den
    );
        return (den == '0) ? '0 : num % den;
    endfunction

    // element [i][j] of a packed 2x2 matrix
    function automatic logic [1:0] elem(input erithcrypt_pkg::data_t m, input int i, input int j);
        return m[6 - 2 * (2 * i + j) +: 2];
    endfunction

    // element-wise add, 2-bit fields wrap mod 4
    function automatic erithcrypt_pkg::data_t mat_add(
        input erithcrypt_pkg::data_t x,
        input erithcrypt_pkg::data_t y
    );
        erithcrypt_pkg::data_t sum;
        for (int e = 0; e < 4; e++) begin
            sum[2 * e +: 2] = x[2 * e +: 2] + y[2 * e +: 2];
        end
        return sum;
    endfunction

    // row by column products, accumulator wraps mod 4
    function automatic erithcrypt_pkg::data_t mat_mul(
        input erithcrypt_pkg::data_t x,
        input erithcrypt_pkg::data_t y
    );
        erithcrypt_pkg::data_t prod;
        logic [1:0]            acc;
        prod = '0;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                acc = '0;
                for (int k = 0; k < 2; k++) begin
                    acc = acc + 2'(elem(x, i, k) * elem(y, k, j));
                end
                prod[6 - 2 * (2 * i + j) +: 2] = acc;
            end
        end
        return prod;
    endfunction

    // single-cycle ops straight off the fifo head
    // operands for mod already ordered by op_issue
    always_comb begin
        case (head_op)
            erithcrypt_pkg::op_mod:       alu_result = remainder(head_a, head_b);
            erithcrypt_pkg::op_shl:       alu_result = head_b[0] ? head_a << 1 : head_a;
            erithcrypt_pkg::op_shr:       alu_result = head_b[0] ? head_a >> 1 : head_a;
            erithcrypt_pkg::op_mat_add:   alu_result = mat_add(head_a, head_b);
            erithcrypt_pkg::op_mat_mul:   alu_result = mat_mul(head_a, head_b);
            erithcrypt_pkg::op_congruent: alu_result = erithcrypt_pkg::data_t'(
                remainder(head_a, CONG_MOD) == remainder(head_b, CONG_MOD));
            // gcd goes through the engine, op_none never queued
            default:                      alu_result = '0;
        endcase
    end

    // control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= erithcrypt_pkg::st_idle;
            pop          <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            pop          <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                erithcrypt_pkg::st_idle: begin
                    if (pop) begin
                        // head is consumed at this edge
                        if (head_op == erithcrypt_pkg::op_gcd) begin
                            state <= erithcrypt_pkg::st_gcd_run;
                        end else begin
                            result       <= alu_result;
                            result_valid <= 1'b1;
                            state        <= erithcrypt_pkg::st_done;
                        end
                    end else if (!empty) begin
                        pop <= 1'b1;
                    end
                end
                erithcrypt_pkg::st_gcd_run: begin
                    // smaller value hit zero, larger one is the gcd
                    if (gcd_small == '0) begin
                        result       <= gcd_big;
                        result_valid <= 1'b1;
                        state        <= erithcrypt_pkg::st_done;
                    end
                end
                erithcrypt_pkg::st_done: state <= erithcrypt_pkg::st_idle;
                default:                 state <= erithcrypt_pkg::st_idle;
            endcase
        end
    end

    // euclid datapath, (big, small) -> (small, big mod small)
    always_ff @(posedge clk) begin
        if ((state == erithcrypt_pkg::st_idle) && pop) begin
            gcd_big   <= head_a;
            gcd_small <= head_b;
        end else if ((state == erithcrypt_pkg::st_gcd_run) && (gcd_small != '0)) begin
            gcd_big   <= gcd_small;
            gcd_small <= remainder(gcd_big, gcd_small);
        end
    end

endmodule

// ==== verilog/erithcrypt_unit.sv ====
`timescale 1ns/100ps

module erithcrypt_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  erithcrypt_pkg::opcode_t op,
    input  erithcrypt_pkg::data_t   a,
    input  erithcrypt_pkg::data_t   b,
    output logic                    full,
    output logic                    op_error,
    output erithcrypt_pkg::data_t   result,
    output logic                    result_valid
);

    // issue to queue
    logic                    push;
    erithcrypt_pkg::opcode_t push_op;
    erithcrypt_pkg::data_t   push_a;
    erithcrypt_pkg::data_t   push_b;

    // queue to executor
    logic                    pop;
    logic                    empty;
    erithcrypt_pkg::opcode_t head_op;
    erithcrypt_pkg::data_t   head_a;
    erithcrypt_pkg::data_t   head_b;

    // producer, checks and orders commands
    op_issue u_issue (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .op       (op),
        .a        (a),
        .b        (b),
        .push     (push),
        .push_op  (push_op),
        .push_a   (push_a),
        .push_b   (push_b),
        .op_error (op_error)
    );

    // buffer, full goes straight to the caller
    cmd_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .push    (push),
        .push_op (push_op),
        .push_a  (push_a),
        .push_b  (push_b),
        .pop     (pop),
        .head_op (head_op),
        .head_a  (head_a),
        .head_b  (head_b),
        .empty   (empty),
        .full    (full)
    );

    // consumer, results leave in queue order
    op_execute u_exec (
        .clk          (clk),
        .reset        (reset),
        .empty        (empty),
        .head_op      (head_op),
        .head_a       (head_a),
        .head_b       (head_b),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    // 40 ns period, first rising edge at 20 ns
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== testbench/erithcrypt_assert.sv ====
`timescale 1ns/100ps

module erithcrypt_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  start,
    input logic                  full,
    input logic                  op_error,
    input erithcrypt_pkg::data_t result,
    input logic                  result_valid
);

    // a rejected command never also yields a result
    result_error_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(result_valid && op_error)
    ) else $error("result_valid and op_error high in the same cycle");

    // the caller has to hold off while the queue is full
    no_start_while_full: assert property (
        @(posedge clk) disable iff (reset) !(start && full)
    ) else $error("start strobed while full was high");

    // every output driven once reset is gone
    outputs_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown({full, op_error, result, result_valid})
    ) else $error("unknown value on an output of the unit");

endmodule

// ==== testbench/erithcrypt_tb.sv ====
`timescale 1ns/100ps

`include "erithcrypt_config.svh"

module erithcrypt_tb;

    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int QUEUE_DEPTH  = `ERITH_FIFO_DEPTH;
    // cycle limits of the waits
    localparam int ROOM_TIMEOUT     = 100;
    localparam int RESPONSE_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT    = 200;

    logic                    clk;
    logic                    reset;
    logic                    start;
    erithcrypt_pkg::opcode_t op;
    erithcrypt_pkg::data_t   a;
    erithcrypt_pkg::data_t   b;
    logic                    full;
    logic                    op_error;
    erithcrypt_pkg::data_t   result;
    logic                    result_valid;

    // expected responses, oldest command first
    logic                  exp_err_q [$];
    erithcrypt_pkg::data_t exp_res_q [$];
    int                    exp_idx_q [$];
    // legal commands strobed and not yet answered
    int                    pending_results = 0;
    int                    head_age = 0;
    bit                    full_seen = 1'b0;

    tb_clock u_clock (.clk(clk));

    erithcrypt_unit DUT (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .op           (op),
        .a            (a),
        .b            (b),
        .full         (full),
        .op_error     (op_error),
        .result       (result),
        .result_valid (result_valid)
    );

    bind erithcrypt_unit erithcrypt_assert u_protocol (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .full         (full),
        .op_error     (op_error),
        .result       (result),
        .result_valid (result_valid)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input erithcrypt_pkg::data_t got,
                                input erithcrypt_pkg::data_t expected, input int idx);
        if (got !== expected) begin
            $display("** Error: result = 0x%02h, expected 0x%02h (vector %0d)",
                     got, expected, idx);
            abort_run();
        end
    endtask

    task automatic check_error(input logic got, input logic expected, input int idx);
        if (got !== expected) begin
            $display("** Error: op_error = 0x%0h, expected 0x%0h (vector %0d)",
                     got, expected, idx);
            abort_run();
        end
    endtask

    task automatic remove_entry(input int idx);
        exp_err_q.delete(idx);
        exp_res_q.delete(idx);
        exp_idx_q.delete(idx);
        head_age = 0;
    endtask

    // errors overtake results, so match the oldest command still expecting one
    task automatic take_error();
        int found;
        found = -1;
        for (int i = 0; i < exp_err_q.size(); i++) begin
            if (exp_err_q[i] && (found < 0)) found = i;
        end
        if (found < 0) begin
            check_error(op_error, 1'b0, -1);
        end else begin
            remove_entry(found);
        end
    endtask

    // results leave in issue order, head must be a legal command
    task automatic take_result();
        if (exp_err_q.size() == 0) begin
            $display("result_valid pulsed with no command outstanding");
            abort_run();
        end else begin
            check_error(1'b0, exp_err_q[0], exp_idx_q[0]);
            check_result(result, exp_res_q[0], exp_idx_q[0]);
            pending_results--;
            remove_entry(0);
        end
    endtask

    // full lags the issue stage by one cycle
    // a strobe last cycle is not yet counted in it
    // illegal commands wait until no result is outstanding
    // their op_error pulse then never meets result_valid
    task automatic wait_for_room(input bit after_strobe, input bit illegal);
        int waited;
        bit blocked;
        waited  = 0;
        blocked = full || (after_strobe && (pending_results >= QUEUE_DEPTH))
                  || (illegal && (pending_results != 0));
        while (blocked && (waited < ROOM_TIMEOUT)) begin
            start = 1'b0;
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            blocked = full || (illegal && (pending_results != 0));
        end
        if (blocked) begin
            $display("no room for a command after %0d cycles", ROOM_TIMEOUT);
            abort_run();
        end
    endtask

    // one command per golden line, back to back while there is room
    task automatic play_vectors(input int fd);
        string      line;
        int         fields;
        int         count;
        bit         after_strobe;
        logic [3:0] f_op;
        logic [7:0] f_a;
        logic [7:0] f_b;
        logic [7:0] f_res;
        logic [3:0] f_err;
        count        = 0;
        after_strobe = 1'b0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_err);
            if (fields == 5) begin
                wait_for_room(after_strobe, f_err != 0);
                exp_err_q.push_back(f_err != 0);
                exp_res_q.push_back(f_res);
                exp_idx_q.push_back(count);
                if (f_err == 0) pending_results++;
                start = 1'b1;
                op    = erithcrypt_pkg::opcode_t'(f_op);
                a     = f_a;
                b     = f_b;
                @(posedge clk);
                #DRIVE_DELAY;
                after_strobe = 1'b1;
                count++;
            end else if (fields > 0) begin
                $display("golden line after vector %0d has %0d fields", count, fields);
                abort_run();
            end
        end
        start = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((exp_err_q.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_err_q.size() != 0) begin
            $display("%0d responses still missing after %0d cycles",
                     exp_err_q.size(), DRAIN_TIMEOUT);
            abort_run();
        end else begin
            // quiet spell, a duplicate result would show up here
            repeat (8) @(posedge clk);
        end
    endtask

    // outputs sampled mid cycle, well away from the edge
    initial begin : response_checker
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (full) full_seen = 1'b1;
                if (op_error) take_error();
                if (result_valid) take_result();
                head_age = (exp_err_q.size() == 0) ? 0 : head_age + 1;
                if (head_age > RESPONSE_TIMEOUT) begin
                    $display("vector %0d got no response within %0d cycles",
                             exp_idx_q[0], RESPONSE_TIMEOUT);
                    abort_run();
                end
            end
        end
    end

    initial begin : stimulus
        int fd;
        reset = 1'b1;
        start = 1'b0;
        op    = erithcrypt_pkg::op_none;
        a     = '0;
        b     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        fd = $fopen("testbench/erithcrypt_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/erithcrypt_golden.txt");
            abort_run();
        end else begin
            play_vectors(fd);
            $fclose(fd);
            wait_for_drain();
            if (!full_seen) begin
                $display("full never went high, the queue was never filled");
                abort_run();
            end else begin
                $display("Finished with no errors");
                $finish;
            end
        end
    end

endmodule

// ==== testbench/erithcrypt_golden.txt ====
// columns, all hex: opcode a b expected_result expected_error
// expected_result is ignored when expected_error is 1
2 64 07 02 0
2 07 64 02 0
2 2a 00 00 0
3 a5 01 4a 0
3 5c 02 5c 0
4 a5 03 52 0
5 1b e4 ff 0
5 ff 55 00 0
6 1b e4 44 0
6 ff ff aa 0
7 11 2f 01 0
7 11 12 00 0
1 30 12 06 0
1 12 30 06 0
1 23 40 01 0
1 4d 4d 4d 0
1 00 2d 2d 0
0 12 34 00 1
8 55 aa 00 1
f ff ff 00 1
2 0d 04 01 0
1 e9 90 01 0
3 01 01 02 0
9 00 00 00 1
5 12 21 33 0
4 80 01 40 0
7 0a 0f 01 0
2 ff 10 0f 0
1 69 2d 0f 0

// ==== erithcrypt.f ====
+incdir+verilog
verilog/erithcrypt_pkg.sv
verilog/op_issue.sv
verilog/cmd_fifo.sv
verilog/op_execute.sv
verilog/erithcrypt_unit.sv
testbench/tb_clock.sv
testbench/erithcrypt_assert.sv
testbench/erithcrypt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the erithcrypt testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module erithcrypt_tb -f erithcrypt.f \
    --Mdir obj_dir -o erithcrypt_sim

status=0
./obj_dir/erithcrypt_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "FAIL: testbench reported errors"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi
echo "PASS"
